//--- hdl/panel_macros.svh
//####################
// panel geometry and bus widths
//####################

`ifndef PANEL_MACROS_SVH
`define PANEL_MACROS_SVH

// framebuffer size
`define FB_ROWS 8
`define FB_COLS 16

// bits per stored pixel
`define PIXEL_BITS 8

// one enable per brightness bit plane
`define BRIGHTNESS_LEVELS 6

`endif

//--- hdl/panel_pkg.sv
//####################
// panel controller types
// opcodes, pixel, brightness and framebuffer address
//####################

`include "panel_macros.svh"

package panel_pkg;

    localparam int ROW_BITS = $clog2(`FB_ROWS);
    localparam int COL_BITS = $clog2(`FB_COLS);
    localparam int FB_WORDS = `FB_ROWS * `FB_COLS;

    // command bytes, anything else is ignored
    typedef enum logic [7:0] {
        red_enable      = 8'h01,
        red_disable     = 8'h02,
        green_enable    = 8'h03,
        green_disable   = 8'h04,
        blue_enable     = 8'h05,
        blue_disable    = 8'h06,
        brightness_zero = 8'h10,
        brightness_nine = 8'h19,
        read_brightness = 8'h1a,
        blank_panel     = 8'h20,
        fill_panel      = 8'h21,
        read_pixel      = 8'h22
    } opcode_t;

    typedef logic [`PIXEL_BITS-1:0] pixel_t;
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;

    localparam brightness_t BRIGHTNESS_RESET = '1;

    // row-major, row in the upper bits
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } fb_addr_t;

    localparam fb_addr_t FB_LAST_ADDR = fb_addr_t'(FB_WORDS - 1);

endpackage

//--- hdl/fb_write_if.sv
//####################
// framebuffer write request
//####################

`timescale 1ns/10ps

interface fb_write_if;
    import panel_pkg::*;

    logic     req;
    logic     gnt;
    fb_addr_t addr;
    pixel_t   data;

    // addr and data stay put while req waits for gnt
    modport engine (output req, output addr, output data, input gnt);
    modport arbiter (input req, input addr, input data, output gnt);

endinterface

//--- hdl/cmd_decoder.sv
//####################
// command decoder
// byte handshake, opcode dispatch, enables and brightness
//####################

`timescale 1ns/10ps

module cmd_decoder (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic [7:0]             data_rx,
    input  logic                   data_valid,
    input  logic                   fill_busy,
    input  logic                   fill_arg_ready,
    input  logic                   fill_args_done,
    input  logic                   pixel_busy,
    input  logic                   pixel_arg_ready,
    input  logic                   pixel_args_done,
    output logic                   ready_for_data,
    output logic [2:0]             rgb_enable,
    output panel_pkg::brightness_t brightness_enable,
    output logic                   fill_start_blank,
    output logic [7:0]             fill_arg_byte,
    output logic                   fill_arg_valid,
    output logic [7:0]             pixel_arg_byte,
    output logic                   pixel_arg_valid,
    output logic                   args_busy
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_bright_arg,
        st_fill_arg,
        st_pixel_arg
    } state_t;

    state_t      state;
    opcode_t     opcode;
    logic        accept;
    logic [2:0]  rgb_q;
    brightness_t bright_q;

    assign opcode = opcode_t'(data_rx);
    assign accept = data_valid && ready_for_data;

    // stall new framebuffer commands so writes land in command order
    always_comb begin
        ready_for_data = 1'b1;
        case (state)
            st_idle: begin
                if (data_valid) begin
                    case (opcode)
                        blank_panel, fill_panel: ready_for_data = !(fill_busy || pixel_busy);
                        read_pixel: ready_for_data = !pixel_busy;
                        default: ready_for_data = 1'b1;
                    endcase
                end
            end
            st_fill_arg: ready_for_data = fill_arg_ready;
            st_pixel_arg: ready_for_data = pixel_arg_ready;
            default: ready_for_data = 1'b1;
        endcase
    end

    assign fill_start_blank = accept && (state == st_idle) && (opcode == blank_panel);
    assign fill_arg_valid   = accept && (state == st_fill_arg);
    assign pixel_arg_valid  = accept && (state == st_pixel_arg);
    assign fill_arg_byte    = data_rx;
    assign pixel_arg_byte   = data_rx;
    assign args_busy        = (state != st_idle);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= st_idle;
            rgb_q             <= 3'b111;
            bright_q          <= BRIGHTNESS_RESET;
            rgb_enable        <= 3'b111;
            brightness_enable <= BRIGHTNESS_RESET;
        end else begin
            // outputs follow the staged values one edge later
            rgb_enable        <= rgb_q;
            brightness_enable <= bright_q;
            if (accept) begin
                case (state)
                    st_idle: begin
                        case (opcode)
                            red_enable:      rgb_q[0] <= 1'b1;
                            red_disable:     rgb_q[0] <= 1'b0;
                            green_enable:    rgb_q[1] <= 1'b1;
                            green_disable:   rgb_q[1] <= 1'b0;
                            blue_enable:     rgb_q[2] <= 1'b1;
                            blue_disable:    rgb_q[2] <= 1'b0;
                            brightness_zero: bright_q <= '0;
                            brightness_nine: bright_q <= '1;
                            read_brightness: state <= st_bright_arg;
                            fill_panel:      state <= st_fill_arg;
                            read_pixel:      state <= st_pixel_arg;
                            // blank needs no arguments and only pulses the start
                            default:         state <= st_idle;
                        endcase
                    end
                    st_bright_arg: begin
                        bright_q <= brightness_t'(data_rx[$bits(brightness_t)-1:0]);
                        state    <= st_idle;
                    end
                    st_fill_arg: begin
                        if (fill_args_done) begin
                            state <= st_idle;
                        end
                    end
                    st_pixel_arg: begin
                        if (pixel_args_done) begin
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // an engine holds no pending write while its arguments are collected
    a_fill_arg_engine_idle: assert property (@(posedge clk_in) disable iff (reset)
        (state == st_fill_arg) |-> fill_arg_ready);

    a_pixel_arg_engine_idle: assert property (@(posedge clk_in) disable iff (reset)
        (state == st_pixel_arg) |-> pixel_arg_ready);

endmodule

//--- hdl/fill_engine.sv
//####################
// fill engine
// writes one colour to every pixel in row-major order
//####################

`timescale 1ns/10ps

module fill_engine (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       start_blank,
    input  logic [7:0] arg_byte,
    input  logic       arg_valid,
    output logic       arg_ready,
    output logic       args_done,
    output logic       busy,
    fb_write_if.engine wr
);
    import panel_pkg::*;

    logic [$bits(fb_addr_t)-1:0] addr_cnt;

    assign wr.addr   = fb_addr_t'(addr_cnt);
    assign arg_ready = !wr.req;
    // single colour byte
    assign args_done = arg_valid;
    assign busy      = wr.req;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr.req   <= 1'b0;
            addr_cnt <= '0;
        end else if (!wr.req && (start_blank || arg_valid)) begin
            wr.req   <= 1'b1;
            addr_cnt <= '0;
        end else if (wr.req && wr.gnt) begin
            if (wr.addr == FB_LAST_ADDR) begin
                wr.req <= 1'b0;
            end else begin
                addr_cnt <= addr_cnt + 1'b1;
            end
        end
    end

    // blank is a fill with zero
    always_ff @(posedge clk_in) begin
        if (!wr.req) begin
            if (start_blank) begin
                wr.data <= '0;
            end else if (arg_valid) begin
                wr.data <= arg_byte;
            end
        end
    end

endmodule

//--- hdl/pixel_engine.sv
//####################
// pixel engine
// collects row, column and colour, then writes one pixel
//####################

`timescale 1ns/10ps

module pixel_engine (
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] arg_byte,
    input  logic       arg_valid,
    output logic       arg_ready,
    output logic       args_done,
    output logic       busy,
    fb_write_if.engine wr
);
    import panel_pkg::*;

    logic [1:0]          byte_cnt;
    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;

    // no new bytes while a write is waiting for its grant
    assign arg_ready = !wr.req;
    assign args_done = arg_valid && (byte_cnt == 2'd2);
    assign busy      = wr.req || (byte_cnt != 2'd0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            byte_cnt <= 2'd0;
            wr.req   <= 1'b0;
        end else begin
            if (arg_valid) begin
                byte_cnt <= args_done ? 2'd0 : byte_cnt + 2'd1;
            end
            if (args_done) begin
                wr.req <= 1'b1;
            end else if (wr.gnt) begin
                wr.req <= 1'b0;
            end
        end
    end

    // byte order is row, column, colour
    always_ff @(posedge clk_in) begin
        if (arg_valid) begin
            case (byte_cnt)
                2'd0: row_q <= arg_byte[ROW_BITS-1:0];
                2'd1: col_q <= arg_byte[COL_BITS-1:0];
                2'd2: begin
                    wr.addr <= '{row: row_q, col: col_q};
                    wr.data <= arg_byte;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- hdl/fb_write_arbiter.sv
//####################
// framebuffer write arbiter
// fill engine first, pixel engine when fill is quiet
//####################

`timescale 1ns/10ps

module fb_write_arbiter (
    input  logic                clk_in,
    input  logic                reset,
    fb_write_if.arbiter         fill_wr,
    fb_write_if.arbiter         pixel_wr,
    output panel_pkg::fb_addr_t ram_address,
    output panel_pkg::pixel_t   ram_data_out,
    output logic                ram_write_enable
);

    assign fill_wr.gnt  = fill_wr.req;
    assign pixel_wr.gnt = pixel_wr.req && !fill_wr.req;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= fill_wr.gnt || pixel_wr.gnt;
        end
    end

    // winner goes out on the port one cycle later
    always_ff @(posedge clk_in) begin
        if (fill_wr.gnt) begin
            ram_address  <= fill_wr.addr;
            ram_data_out <= fill_wr.data;
        end else if (pixel_wr.gnt) begin
            ram_address  <= pixel_wr.addr;
            ram_data_out <= pixel_wr.data;
        end
    end

    // a waiting pixel request keeps its address and data
    a_pixel_req_held: assert property (@(posedge clk_in) disable iff (reset)
        pixel_wr.req && !pixel_wr.gnt |=> pixel_wr.req && $stable(pixel_wr.addr)
            && $stable(pixel_wr.data));

    // fill sweep moves to the next address after each grant
    a_fill_sweep_step: assert property (@(posedge clk_in) disable iff (reset)
        fill_wr.gnt |=> !fill_wr.req
            || ({1'b0, fill_wr.addr} == {1'b0, $past(fill_wr.addr)} + 1'b1));

endmodule

//--- hdl/panel_ctrl_top.sv
//####################
// LED panel controller top
// decoder, two write engines and the write arbiter
//####################

`timescale 1ns/10ps

module panel_ctrl_top (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic [7:0]             data_rx,
    input  logic                   data_valid,
    output logic                   ready_for_data,
    output logic [2:0]             rgb_enable,
    output panel_pkg::brightness_t brightness_enable,
    output panel_pkg::fb_addr_t    ram_address,
    output panel_pkg::pixel_t      ram_data_out,
    output logic                   ram_write_enable,
    output logic                   busy
);

    logic       fill_start_blank;
    logic [7:0] fill_arg_byte;
    logic       fill_arg_valid;
    logic       fill_arg_ready;
    logic       fill_args_done;
    logic       fill_busy;
    logic [7:0] pixel_arg_byte;
    logic       pixel_arg_valid;
    logic       pixel_arg_ready;
    logic       pixel_args_done;
    logic       pixel_busy;
    logic       args_busy;

    fb_write_if fill_wr ();
    fb_write_if pixel_wr ();

    assign busy = args_busy || fill_busy || pixel_busy;

    cmd_decoder cmd_decoder_inst (
        .clk_in, .reset, .data_rx, .data_valid,
        .fill_busy, .fill_arg_ready, .fill_args_done,
        .pixel_busy, .pixel_arg_ready, .pixel_args_done,
        .ready_for_data, .rgb_enable, .brightness_enable,
        .fill_start_blank, .fill_arg_byte, .fill_arg_valid,
        .pixel_arg_byte, .pixel_arg_valid, .args_busy
    );

    fill_engine fill_engine_inst (
        .clk_in, .reset,
        .start_blank (fill_start_blank),
        .arg_byte    (fill_arg_byte),
        .arg_valid   (fill_arg_valid),
        .arg_ready   (fill_arg_ready),
        .args_done   (fill_args_done),
        .busy        (fill_busy),
        .wr          (fill_wr.engine)
    );

    pixel_engine pixel_engine_inst (
        .clk_in, .reset,
        .arg_byte    (pixel_arg_byte),
        .arg_valid   (pixel_arg_valid),
        .arg_ready   (pixel_arg_ready),
        .args_done   (pixel_args_done),
        .busy        (pixel_busy),
        .wr          (pixel_wr.engine)
    );

    fb_write_arbiter fb_write_arbiter_inst (
        .clk_in, .reset,
        .fill_wr     (fill_wr.arbiter),
        .pixel_wr    (pixel_wr.arbiter),
        .ram_address, .ram_data_out, .ram_write_enable
    );

endmodule

//--- bench/panel_ctrl_checker.sv
//####################
// panel controller checker
// reference model, shadow framebuffer and comparisons
//####################

`timescale 1ns/10ps

`include "panel_macros.svh"

module panel_ctrl_checker (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic [7:0]             data_rx,
    input  logic                   data_valid,
    input  logic                   ready_for_data,
    input  logic [2:0]             rgb_enable,
    input  panel_pkg::brightness_t brightness_enable,
    input  panel_pkg::fb_addr_t    ram_address,
    input  panel_pkg::pixel_t      ram_data_out,
    input  logic                   ram_write_enable,
    input  logic                   busy,
    input  logic                   drained,
    output logic                   compare_done,
    output int                     error_count,
    output int                     check_count
);
    import panel_pkg::*;

    localparam int WORDS = `FB_ROWS * `FB_COLS;

    // kinds of expected write
    localparam logic [1:0] KIND_PIXEL      = 2'd0;
    localparam logic [1:0] KIND_FILL_FIRST = 2'd1;
    localparam logic [1:0] KIND_FILL_NEXT  = 2'd2;

    logic [2:0]  model_rgb;
    logic [2:0]  rgb_lag;
    brightness_t model_bright;
    brightness_t bright_lag;
    pixel_t      model_fb [WORDS];
    pixel_t      shadow_fb [WORDS];
    // {kind, address, data} with the oldest command first
    logic [16:0] exp_writes [$];
    logic [7:0]  arg_op;
    logic [7:0]  row_byte;
    logic [7:0]  col_byte;
    int          arg_left;
    int          pixel_pending;
    int          cyc;
    int          due_cyc;
    logic        prev_we;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("error in cycle %0d: %s", cyc, what);
    endtask

    // an idle port writes one cycle after the start edge
    function automatic void set_due();
        if (exp_writes.size() == 0) begin
            due_cyc = cyc + 2;
        end
    endfunction

    function automatic void start_fill(input pixel_t colour);
        set_due();
        for (int a = 0; a < WORDS; a++) begin
            model_fb[a] = colour;
            exp_writes.push_back({(a == 0) ? KIND_FILL_FIRST : KIND_FILL_NEXT, 7'(a), colour});
        end
    endfunction

    function automatic void push_pixel(input pixel_t colour);
        int idx;
        idx = (int'(row_byte) % `FB_ROWS) * `FB_COLS + (int'(col_byte) % `FB_COLS);
        set_due();
        model_fb[idx] = colour;
        exp_writes.push_back({KIND_PIXEL, 7'(idx), colour});
        pixel_pending++;
    endfunction

    // reference model fed one accepted byte at a time
    function automatic void apply_byte(input logic [7:0] b);
        if (arg_left == 0) begin
            arg_op = b;
            case (b)
                red_enable:      model_rgb[0] = 1'b1;
                red_disable:     model_rgb[0] = 1'b0;
                green_enable:    model_rgb[1] = 1'b1;
                green_disable:   model_rgb[1] = 1'b0;
                blue_enable:     model_rgb[2] = 1'b1;
                blue_disable:    model_rgb[2] = 1'b0;
                brightness_zero: model_bright = '0;
                brightness_nine: model_bright = '1;
                read_brightness: arg_left = 1;
                blank_panel:     start_fill('0);
                fill_panel:      arg_left = 1;
                read_pixel:      arg_left = 3;
                default:         arg_left = 0;
            endcase
        end else begin
            arg_left--;
            if (arg_op == read_brightness) begin
                model_bright = b[`BRIGHTNESS_LEVELS-1:0];
            end else if (arg_op == fill_panel) begin
                start_fill(b);
            end else if (arg_left == 2) begin
                row_byte = b;
            end else if (arg_left == 1) begin
                col_byte = b;
            end else begin
                push_pixel(b);
            end
        end
    endfunction

    task automatic final_compare();
        if (exp_writes.size() != 0) begin
            report_error("framebuffer writes still missing after the drain");
        end
        for (int a = 0; a < WORDS; a++) begin
            check_value($sformatf("framebuffer[%0d]", a), model_fb[a], shadow_fb[a]);
        end
        compare_done = 1'b1;
    endtask

    always @(posedge clk_in) begin
        logic [16:0] entry;
        logic        exp_ready;
        logic        exp_busy;
        if (reset) begin
            model_rgb     = 3'b111;
            rgb_lag       = 3'b111;
            model_bright  = '1;
            bright_lag    = '1;
            arg_left      = 0;
            pixel_pending = 0;
            cyc           = 0;
            due_cyc       = -1;
            prev_we       = 1'b0;
            compare_done  = 1'b0;
            error_count   = 0;
            check_count   = 0;
            exp_writes.delete();
            for (int a = 0; a < WORDS; a++) begin
                model_fb[a]  = '0;
                shadow_fb[a] = '0;
            end
        end else if (drained) begin
            if (!compare_done) begin
                final_compare();
            end
        end else begin
            cyc++;
            // enables show the model one cycle behind
            check_value("rgb_enable", rgb_lag, rgb_enable);
            check_value("brightness_enable", bright_lag, brightness_enable);
            rgb_lag    = model_rgb;
            bright_lag = model_bright;
            if (cyc == 1) begin
                check_value("ram_write_enable", 1'b0, ram_write_enable);
            end
            if (cyc == due_cyc && !ram_write_enable) begin
                report_error("no framebuffer write in the cycle after the start");
            end
            if (ram_write_enable) begin
                shadow_fb[int'(ram_address)] = ram_data_out;
                if (exp_writes.size() == 0) begin
                    report_error("framebuffer write that no command asked for");
                end else begin
                    entry = exp_writes.pop_front();
                    check_value("ram_address", entry[14:8], ram_address);
                    check_value("ram_data_out", entry[7:0], ram_data_out);
                    if (entry[16:15] == KIND_FILL_NEXT && !prev_we) begin
                        report_error("gap inside a fill sweep");
                    end
                    if (entry[16:15] == KIND_PIXEL) begin
                        pixel_pending--;
                    end
                end
            end
            prev_we = ram_write_enable;
            // busy while arguments or framebuffer writes are outstanding
            exp_busy = (exp_writes.size() != 0) || (arg_left != 0);
            check_value("busy", exp_busy, busy);
            // stalls that keep writes in command order
            exp_ready = 1'b1;
            if (arg_left == 0 && data_valid) begin
                if ((data_rx == blank_panel || data_rx == fill_panel) && exp_writes.size() != 0) begin
                    exp_ready = 1'b0;
                end
                if (data_rx == read_pixel && pixel_pending != 0) begin
                    exp_ready = 1'b0;
                end
            end
            check_value("ready_for_data", exp_ready, ready_for_data);
            if (data_valid && ready_for_data) begin
                apply_byte(data_rx);
            end
        end
    end

endmodule

//--- bench/panel_ctrl_tb.sv
//####################
// panel controller testbench
// clock, reset, random commands and timeout
//####################

`timescale 1ns/10ps

module panel_ctrl_tb;
    import panel_pkg::*;

    localparam int          NUM_CMDS   = 60;
    localparam int          MAX_CYCLES = NUM_CMDS * 140 + 500;
    localparam logic [31:0] SEED       = 32'h1d5057da;

    logic        clk_in;
    logic        reset;
    logic [7:0]  data_rx;
    logic        data_valid;
    logic        ready_for_data;
    logic [2:0]  rgb_enable;
    brightness_t brightness_enable;
    fb_addr_t    ram_address;
    pixel_t      ram_data_out;
    logic        ram_write_enable;
    logic        busy;
    logic        drained;
    logic        compare_done;
    int          error_count;
    int          check_count;
    logic [31:0] lfsr;
    int          cycles;

    panel_ctrl_top panel_ctrl_top_inst (.*);

    panel_ctrl_checker panel_ctrl_checker_inst (.*);

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never drained", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // galois LFSR, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // read_pixel weighted three times
    function automatic logic [7:0] choose_opcode(input logic [3:0] pick);
        case (pick)
            4'd0:    return red_enable;
            4'd1:    return red_disable;
            4'd2:    return green_enable;
            4'd3:    return green_disable;
            4'd4:    return blue_enable;
            4'd5:    return blue_disable;
            4'd6:    return brightness_zero;
            4'd7:    return brightness_nine;
            4'd8:    return read_brightness;
            4'd9:    return blank_panel;
            4'd10:   return fill_panel;
            default: return read_pixel;
        endcase
    endfunction

    task automatic send_byte(input logic [7:0] b);
        data_rx    <= b;
        data_valid <= 1'b1;
        do begin
            @(posedge clk_in);
        end while (!ready_for_data);
        data_valid <= 1'b0;
        repeat (rand_bits(2)) @(posedge clk_in);
    endtask

    task automatic send_command();
        logic [7:0] pick;
        logic [7:0] op;
        pick = rand_bits(4);
        if (pick >= 8'd14) begin
            // 0xe0 and up decode to nothing
            op = 8'he0 | rand_bits(5);
        end else begin
            op = choose_opcode(pick[3:0]);
        end
        send_byte(op);
        if (op == read_brightness || op == fill_panel) begin
            send_byte(rand_bits(8));
        end else if (op == read_pixel) begin
            repeat (3) send_byte(rand_bits(8));
        end
    endtask

    initial begin
        clk_in     = 1'b0;
        reset      = 1'b1;
        data_rx    = '0;
        data_valid = 1'b0;
        drained    = 1'b0;
        lfsr       = SEED;
        cycles     = 0;
        repeat (10) @(posedge clk_in);
        reset <= 1'b0;
        @(posedge clk_in);
        for (int i = 0; i < NUM_CMDS; i++) begin
            send_command();
        end
        repeat (2) @(posedge clk_in);
        while (busy) begin
            @(posedge clk_in);
        end
        repeat (3) @(posedge clk_in);
        drained <= 1'b1;
        do begin
            @(posedge clk_in);
        end while (!compare_done);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/panel_pkg.sv
hdl/fb_write_if.sv
hdl/cmd_decoder.sv
hdl/fill_engine.sv
hdl/pixel_engine.sv
hdl/fb_write_arbiter.sv
hdl/panel_ctrl_top.sv
bench/panel_ctrl_checker.sv
bench/panel_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= panel_ctrl_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
